//--- source/blockRegs_cfg.svh
/* Configuration for the blockRegs APB register block
   Table depth, address map, bus widths and reset pattern strides */
`ifndef BLOCK_REGS_CFG_SVH
`define BLOCK_REGS_CFG_SVH

`define BLOCK_TABLE_DEPTH 32
`define BLOCK_INDEX_BITS 5

`define BLOCK_ADDR_BITS 12
`define BLOCK_DATA_BITS 32
`define BLOCK_LOCAL_BITS 8
`define BLOCK_WIDE_BITS 37

`define BLOCK_CTRL_ADDR 12'h000
`define BLOCK_STATUS_ADDR 12'h004
`define BLOCK_STAGE_ADDR 12'h008
`define BLOCK_LOCAL_BASE 12'h100
`define BLOCK_WIDE_BASE 12'h200

`define BLOCK_LOCAL_STRIDE 64'h22
`define BLOCK_WIDE_STRIDE 64'h1_0000_0001

`endif

//--- source/blockRegsPkg.sv
/* blockRegs shared types
   Entry types for the two tables and the operation and response enums */
`default_nettype none

`include "blockRegs_cfg.svh"

package blockRegsPkg;

    // Local table entry, also used for control and status
    typedef logic [`BLOCK_LOCAL_BITS-1:0] localEntry;

    typedef logic [`BLOCK_WIDE_BITS-1:0] wideEntry;

    // Bits of a wide entry above the bus word
    typedef logic [`BLOCK_WIDE_BITS-`BLOCK_DATA_BITS-1:0] wideHigh;

    typedef enum logic [3:0] {
        opNone,
        opCtrlWr,
        opCtrlRd,
        opStatusRd,
        opStageWr,
        opStageRd,
        opLocalWr,
        opLocalRd,
        opWideWr,
        opWideRd,
        opError
    } accessOp;

    typedef enum logic {
        respIdle,
        respTableWait
    } respState;

endpackage

`default_nettype wire

//--- source/apbDecode.sv
/* apbDecode
   Classifies each APB setup phase into an operation and a table index,
   then presents it for one cycle at the start of the access phase */
`include "blockRegs_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module apbDecode (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [`BLOCK_ADDR_BITS-1:0]   paddr,
    input  logic [`BLOCK_DATA_BITS-1:0]   pwdata,
    output logic                          opValid,
    output blockRegsPkg::accessOp         opCode,
    output logic [`BLOCK_INDEX_BITS-1:0]  tableIndex,
    output logic [`BLOCK_DATA_BITS-1:0]   writeData
);

    // One word per entry, so a window spans index bits plus byte offset
    localparam int WindowShift = `BLOCK_INDEX_BITS + 2;

    logic                  setupPhase;
    logic                  aligned;
    logic                  localHit;
    logic                  wideHit;
    blockRegsPkg::accessOp nextOp;

    assign setupPhase = psel && !penable;
    assign aligned = (paddr[1:0] == 2'b00);
    assign localHit = (paddr >> WindowShift) == (`BLOCK_LOCAL_BASE >> WindowShift);
    assign wideHit = (paddr >> WindowShift) == (`BLOCK_WIDE_BASE >> WindowShift);

    always_comb begin
        nextOp = blockRegsPkg::opError;
        if (aligned) begin
            if (localHit) begin
                nextOp = pwrite ? blockRegsPkg::opLocalWr : blockRegsPkg::opLocalRd;
            end else if (wideHit) begin
                nextOp = pwrite ? blockRegsPkg::opWideWr : blockRegsPkg::opWideRd;
            end else begin
                case (paddr)
                    `BLOCK_CTRL_ADDR: begin
                        nextOp = pwrite ? blockRegsPkg::opCtrlWr : blockRegsPkg::opCtrlRd;
                    end
                    `BLOCK_STATUS_ADDR: begin
                        // Status is read only
                        nextOp = pwrite ? blockRegsPkg::opError : blockRegsPkg::opStatusRd;
                    end
                    `BLOCK_STAGE_ADDR: begin
                        nextOp = pwrite ? blockRegsPkg::opStageWr : blockRegsPkg::opStageRd;
                    end
                    default: begin
                        nextOp = blockRegsPkg::opError;
                    end
                endcase
            end
        end
    end

    // Setup lasts exactly one cycle, so opValid is a single pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opValid <= 1'b0;
            opCode <= blockRegsPkg::opNone;
        end else begin
            opValid <= setupPhase;
            if (setupPhase) begin
                opCode <= nextOp;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tableIndex <= '0;
            writeData <= '0;
        end else if (setupPhase) begin
            tableIndex <= paddr[WindowShift-1:2];
            writeData <= pwdata;
        end
    end

endmodule

`default_nettype wire

//--- source/tableMemory.sv
/* tableMemory
   Single-port table with a registered read port
   Reset loads entry i with i times InitStride, cut to the entry width */
`include "blockRegs_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module tableMemory #(
    parameter int          DataWidth  = `BLOCK_LOCAL_BITS,
    parameter logic [63:0] InitStride = `BLOCK_LOCAL_STRIDE
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         enable,
    input  logic                         writeEnable,
    input  logic [`BLOCK_INDEX_BITS-1:0] index,
    input  logic [DataWidth-1:0]         writeData,
    output logic [DataWidth-1:0]         readData
);

    logic [DataWidth-1:0] entries [`BLOCK_TABLE_DEPTH];

    // Read returns the entry as it was before a write in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `BLOCK_TABLE_DEPTH; i++) begin
                entries[i] <= DataWidth'(64'(i) * InitStride);
            end
            readData <= '0;
        end else if (enable) begin
            if (writeEnable) begin
                entries[index] <= writeData;
            end
            readData <= entries[index];
        end
    end

endmodule

`default_nettype wire

//--- source/regExecute.sv
/* regExecute
   Carries out decoded operations on the control, status and staging
   registers and drives the local and wide tables */
`include "blockRegs_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module regExecute (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          opValid,
    input  blockRegsPkg::accessOp         opCode,
    input  logic [`BLOCK_INDEX_BITS-1:0]  tableIndex,
    input  logic [`BLOCK_DATA_BITS-1:0]   writeData,
    output logic [`BLOCK_DATA_BITS-1:0]   regReadData,
    output blockRegsPkg::localEntry       localReadData,
    output logic [`BLOCK_DATA_BITS-1:0]   wideReadLow
);

    blockRegsPkg::localEntry ctrlReg;
    blockRegsPkg::localEntry writeCount;
    blockRegsPkg::wideHigh   stageReg;
    blockRegsPkg::wideEntry  wideReadData;
    blockRegsPkg::wideEntry  wideWriteData;
    logic                    localEnable;
    logic                    localWriteEnable;
    logic                    wideEnable;
    logic                    wideWriteEnable;
    logic                    wideReadPending;

    assign localEnable = opValid && (opCode == blockRegsPkg::opLocalWr ||
                                     opCode == blockRegsPkg::opLocalRd);
    assign localWriteEnable = opValid && (opCode == blockRegsPkg::opLocalWr);
    assign wideEnable = opValid && (opCode == blockRegsPkg::opWideWr ||
                                    opCode == blockRegsPkg::opWideRd);
    assign wideWriteEnable = opValid && (opCode == blockRegsPkg::opWideWr);

    // Upper bits come from staging, the bus word fills the rest
    assign wideWriteData = {stageReg, writeData};
    assign wideReadLow = wideReadData[`BLOCK_DATA_BITS-1:0];

    tableMemory #(
        .DataWidth  (`BLOCK_LOCAL_BITS),
        .InitStride (`BLOCK_LOCAL_STRIDE)
    ) localTable (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (localEnable),
        .writeEnable (localWriteEnable),
        .index       (tableIndex),
        .writeData   (writeData[`BLOCK_LOCAL_BITS-1:0]),
        .readData    (localReadData)
    );

    tableMemory #(
        .DataWidth  (`BLOCK_WIDE_BITS),
        .InitStride (`BLOCK_WIDE_STRIDE)
    ) wideTable (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (wideEnable),
        .writeEnable (wideWriteEnable),
        .index       (tableIndex),
        .writeData   (wideWriteData),
        .readData    (wideReadData)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrlReg <= '0;
            writeCount <= '0;
            stageReg <= '0;
            wideReadPending <= 1'b0;
        end else begin
            wideReadPending <= opValid && (opCode == blockRegsPkg::opWideRd);
            if (opValid && opCode == blockRegsPkg::opCtrlWr) begin
                ctrlReg <= writeData[`BLOCK_LOCAL_BITS-1:0];
            end
            // Wraps at 256
            if (localWriteEnable || wideWriteEnable) begin
                writeCount <= writeCount + 1'b1;
            end
            // Wide read data lands one cycle after the enable
            if (wideReadPending) begin
                stageReg <= wideReadData[`BLOCK_WIDE_BITS-1:`BLOCK_DATA_BITS];
            end else if (opValid && opCode == blockRegsPkg::opStageWr) begin
                stageReg <= writeData[`BLOCK_WIDE_BITS-`BLOCK_DATA_BITS-1:0];
            end
        end
    end

    always_comb begin
        case (opCode)
            blockRegsPkg::opCtrlRd:   regReadData = `BLOCK_DATA_BITS'(ctrlReg);
            blockRegsPkg::opStatusRd: regReadData = `BLOCK_DATA_BITS'(writeCount);
            blockRegsPkg::opStageRd:  regReadData = `BLOCK_DATA_BITS'(stageReg);
            default:                  regReadData = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/readResult.sv
/* readResult
   Builds the APB response and holds table accesses for one wait state */
`include "blockRegs_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module readResult (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        opValid,
    input  blockRegsPkg::accessOp       opCode,
    input  logic [`BLOCK_DATA_BITS-1:0] regReadData,
    input  logic [`BLOCK_DATA_BITS-1:0] wideReadLow,
    input  blockRegsPkg::localEntry     localReadData,
    output logic [`BLOCK_DATA_BITS-1:0] prdata,
    output logic                        pready,
    output logic                        pslverr
);

    blockRegsPkg::respState      state;
    blockRegsPkg::respState      nextState;
    logic                        tableOp;
    logic [`BLOCK_DATA_BITS-1:0] readSelect;

    assign tableOp = opCode inside {blockRegsPkg::opLocalWr, blockRegsPkg::opLocalRd,
                                    blockRegsPkg::opWideWr, blockRegsPkg::opWideRd};

    always_comb begin
        nextState = state;
        case (state)
            blockRegsPkg::respIdle: begin
                if (opValid && tableOp) begin
                    nextState = blockRegsPkg::respTableWait;
                end
            end
            blockRegsPkg::respTableWait: begin
                nextState = blockRegsPkg::respIdle;
            end
            default: begin
                nextState = blockRegsPkg::respIdle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= blockRegsPkg::respIdle;
        end else begin
            state <= nextState;
        end
    end

    // Registers and errors finish at once, tables after the read latency
    assign pready = (opValid && !tableOp) || (state == blockRegsPkg::respTableWait);
    assign pslverr = opValid && (opCode == blockRegsPkg::opError);

    always_comb begin
        case (opCode)
            blockRegsPkg::opLocalRd:  readSelect = `BLOCK_DATA_BITS'(localReadData);
            blockRegsPkg::opWideRd:   readSelect = wideReadLow;
            blockRegsPkg::opCtrlRd,
            blockRegsPkg::opStatusRd,
            blockRegsPkg::opStageRd:  readSelect = regReadData;
            default:                  readSelect = '0;
        endcase
    end

    // Bus data is zero outside the completing cycle
    assign prdata = pready ? readSelect : '0;

endmodule

`default_nettype wire

//--- source/blockRegs.sv
/* blockRegs top level
   APB register block with control, status, staging and two tables */
`include "blockRegs_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module blockRegs (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`BLOCK_ADDR_BITS-1:0] paddr,
    input  logic [`BLOCK_DATA_BITS-1:0] pwdata,
    output logic [`BLOCK_DATA_BITS-1:0] prdata,
    output logic                        pready,
    output logic                        pslverr
);

    // Decoded transfer
    logic                         opValid;
    blockRegsPkg::accessOp        opCode;
    logic [`BLOCK_INDEX_BITS-1:0] tableIndex;
    logic [`BLOCK_DATA_BITS-1:0]  writeData;

    // Read sources
    logic [`BLOCK_DATA_BITS-1:0]  regReadData;
    blockRegsPkg::localEntry      localReadData;
    logic [`BLOCK_DATA_BITS-1:0]  wideReadLow;

    apbDecode apbDecodeInst (
        .clk        (clk),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .opValid    (opValid),
        .opCode     (opCode),
        .tableIndex (tableIndex),
        .writeData  (writeData)
    );

    regExecute regExecuteInst (
        .clk           (clk),
        .rst_n         (rst_n),
        .opValid       (opValid),
        .opCode        (opCode),
        .tableIndex    (tableIndex),
        .writeData     (writeData),
        .regReadData   (regReadData),
        .localReadData (localReadData),
        .wideReadLow   (wideReadLow)
    );

    readResult readResultInst (
        .clk           (clk),
        .rst_n         (rst_n),
        .opValid       (opValid),
        .opCode        (opCode),
        .regReadData   (regReadData),
        .wideReadLow   (wideReadLow),
        .localReadData (localReadData),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr)
    );

endmodule

`default_nettype wire

//--- bench/blockRegsTb.sv
/* blockRegs testbench
   Runs APB transfers against a reference model of the registers and tables,
   and checks read data, wait states and error responses */
`include "blockRegs_cfg.svh"
`timescale 1ns/1ps
`default_nettype none

module blockRegsTb;

    localparam int ClkPeriod = 8;
    localparam int ResetCycles = 4;
    localparam int DriveDelay = 1;
    localparam int TransferBudget = 200;
    localparam int CyclesPerTransfer = 4;
    localparam int MarginCycles = 100;
    localparam int TimeoutNs = (TransferBudget * CyclesPerTransfer + ResetCycles
                                + MarginCycles) * ClkPeriod;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // Reference model state
    logic [7:0]  localModel [`BLOCK_TABLE_DEPTH];
    logic [36:0] wideModel [`BLOCK_TABLE_DEPTH];
    logic [7:0]  ctrlModel;
    logic [4:0]  stageModel;
    logic [7:0]  writeCountModel;

    integer seed;

    // Response of the most recent transfer
    logic [31:0] lastData;
    logic        lastErr;
    int          lastWaits;

    blockRegs blockRegs_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // Watchdog sized for the whole transfer budget
    initial begin
        #(TimeoutNs);
        $display("The run hung: the watchdog expired after %0d ns", TimeoutNs);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic reportMismatch(input string what);
        $display("error at time %0t: %s", $time, what);
        $display("STATUS: FAIL");
        $fatal(1, "check failed");
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    // Reset pattern of both tables
    task automatic initModel();
        for (int i = 0; i < `BLOCK_TABLE_DEPTH; i++) begin
            localModel[i] = 8'(i * 'h22);
            // Wide entries repeat the index above the bus word
            wideModel[i] = {5'(i), 32'(i)};
        end
        ctrlModel = '0;
        stageModel = '0;
        writeCountModel = '0;
    endtask

    function automatic logic [11:0] localAddr(input logic [4:0] idx);
        return `BLOCK_LOCAL_BASE + {5'b0, idx, 2'b00};
    endfunction

    function automatic logic [11:0] wideAddr(input logic [4:0] idx);
        return `BLOCK_WIDE_BASE + {5'b0, idx, 2'b00};
    endfunction

    // One APB transfer, counting access cycles until pready
    task automatic apbAccess(input logic write, input logic [11:0] addr,
                             input logic [31:0] data);
        int accessCycles;
        @(posedge clk);
        #DriveDelay;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = data;
        @(posedge clk);
        #DriveDelay;
        penable = 1'b1;
        accessCycles = 1;
        @(negedge clk);
        while (!pready) begin
            if (accessCycles >= 4) begin
                abortRun($sformatf("pready never rose for address 0x%03h", addr));
            end
            @(posedge clk);
            #DriveDelay;
            accessCycles++;
            @(negedge clk);
        end
        lastData = prdata;
        lastErr = pslverr;
        lastWaits = accessCycles - 1;
        @(posedge clk);
        #DriveDelay;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic expectResult(input string label, input logic [31:0] expData,
                                input logic expErr, input int expWaits,
                                input logic dataMatters);
        assert (lastErr == expErr)
            else reportMismatch($sformatf("%s: pslverr %0b, expected %0b",
                                          label, lastErr, expErr));
        assert (lastWaits == expWaits)
            else reportMismatch($sformatf("%s: %0d wait states, expected %0d",
                                          label, lastWaits, expWaits));
        assert (!dataMatters || lastData == expData)
            else reportMismatch($sformatf("%s: prdata 0x%08h, expected 0x%08h",
                                          label, lastData, expData));
    endtask

    task automatic writeCtrl(input logic [31:0] value);
        apbAccess(1'b1, `BLOCK_CTRL_ADDR, value);
        expectResult("ctrl write", '0, 1'b0, 0, 1'b0);
        ctrlModel = value[7:0];
    endtask

    task automatic readCtrl();
        apbAccess(1'b0, `BLOCK_CTRL_ADDR, '0);
        expectResult("ctrl read", {24'b0, ctrlModel}, 1'b0, 0, 1'b1);
    endtask

    task automatic readStatus();
        apbAccess(1'b0, `BLOCK_STATUS_ADDR, '0);
        expectResult("status read", {24'b0, writeCountModel}, 1'b0, 0, 1'b1);
    endtask

    task automatic writeStage(input logic [31:0] value);
        apbAccess(1'b1, `BLOCK_STAGE_ADDR, value);
        expectResult("stage write", '0, 1'b0, 0, 1'b0);
        stageModel = value[4:0];
    endtask

    task automatic readStage();
        apbAccess(1'b0, `BLOCK_STAGE_ADDR, '0);
        expectResult("stage read", {27'b0, stageModel}, 1'b0, 0, 1'b1);
    endtask

    task automatic writeLocal(input logic [4:0] idx, input logic [31:0] value);
        apbAccess(1'b1, localAddr(idx), value);
        expectResult($sformatf("local write %0d", idx), '0, 1'b0, 1, 1'b0);
        localModel[idx] = value[7:0];
        writeCountModel++;
    endtask

    task automatic readLocal(input logic [4:0] idx);
        apbAccess(1'b0, localAddr(idx), '0);
        expectResult($sformatf("local read %0d", idx), {24'b0, localModel[idx]},
                     1'b0, 1, 1'b1);
    endtask

    // Upper bits of the entry come from staging
    task automatic writeWide(input logic [4:0] idx, input logic [31:0] low);
        apbAccess(1'b1, wideAddr(idx), low);
        expectResult($sformatf("wide write %0d", idx), '0, 1'b0, 1, 1'b0);
        wideModel[idx] = {stageModel, low};
        writeCountModel++;
    endtask

    task automatic readWide(input logic [4:0] idx);
        apbAccess(1'b0, wideAddr(idx), '0);
        expectResult($sformatf("wide read %0d", idx), wideModel[idx][31:0],
                     1'b0, 1, 1'b1);
        stageModel = wideModel[idx][36:32];
    endtask

    task automatic expectError(input logic write, input logic [11:0] addr,
                               input logic [31:0] data);
        apbAccess(write, addr, data);
        expectResult($sformatf("error access 0x%03h", addr), '0, 1'b1, 0, 1'b1);
    endtask

    initial begin
        logic [4:0] idx;
        logic [4:0] picked [12];
        seed = 32'h7236_91f0;
        rst_n = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        initModel();
        repeat (ResetCycles) @(posedge clk);
        #DriveDelay;
        assert (!pready && !pslverr)
            else reportMismatch("bus response active during reset");
        rst_n = 1'b1;

        // Reset pattern, staging picks up the wide index
        for (int i = 0; i < `BLOCK_TABLE_DEPTH; i++) begin
            readLocal(5'(i));
            readWide(5'(i));
            readStage();
        end

        writeCtrl(32'h0000_00a5);
        readCtrl();
        writeCtrl(32'hffff_ff3c);
        readCtrl();
        repeat (2) begin
            writeCtrl($random(seed));
            readCtrl();
        end

        // Random local traffic, repeats of an index resolve in the model
        for (int n = 0; n < 12; n++) begin
            picked[n] = 5'($random(seed));
            writeLocal(picked[n], $random(seed));
        end
        readStatus();
        for (int n = 0; n < 12; n++) begin
            readLocal(picked[n]);
        end

        // Staging is overwritten before the read to prove the read reloads it
        for (int n = 0; n < 6; n++) begin
            idx = 5'($random(seed));
            writeStage($random(seed));
            writeWide(idx, $random(seed));
            writeStage($random(seed));
            readWide(idx);
            readStage();
        end
        readStatus();

        expectError(1'b0, 12'h00c, '0);
        expectError(1'b1, 12'h180, $random(seed));
        expectError(1'b0, 12'h280, '0);
        expectError(1'b1, 12'hffc, $random(seed));
        expectError(1'b1, 12'h101, $random(seed));
        expectError(1'b1, 12'h206, $random(seed));
        expectError(1'b1, 12'h002, $random(seed));
        expectError(1'b1, `BLOCK_STATUS_ADDR, $random(seed));

        // Error transfers must leave every location untouched
        readCtrl();
        readStatus();
        readStage();
        readLocal(5'd0);
        readWide(5'd1);
        readStage();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- blockRegs.f
+incdir+source
source/blockRegsPkg.sv
source/apbDecode.sv
source/tableMemory.sv
source/regExecute.sv
source/readResult.sv
source/blockRegs.sv
bench/blockRegsTb.sv

//--- runSim.sh
#!/bin/sh
# Builds the blockRegs testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module blockRegsTb -Mdir obj_dir -f blockRegs.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/VblockRegsTb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

echo "Simulation finished cleanly"
exit 0
